// ==== mlacc_ctrl.f ====
+incdir+include
source/mlacc_isa_pkg.sv
source/mlacc_ctrl_pkg.sv
source/inst_fetch.sv
source/vector_sequencer.sv
source/offset_regfile.sv
source/writeback_pipe.sv
source/mlacc_ctrl.sv
bench/mlacc_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := mlacc_ctrl_tb
FILELIST  := mlacc_ctrl.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Finished with no errors
SOURCES   := $(wildcard source/*.sv bench/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/mlacc_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mlacc_cfg.svh"

module mlacc_ctrl_tb;
    import mlacc_isa_pkg::*;
    import mlacc_ctrl_pkg::*;

    localparam issue_op_t idle_op = '{funct: funct_nop, lane_mask: 2'd0};

    logic      in_clk;
    logic      in_reset;
    inst_t     in_inst;
    pc_t       out_pc;
    word_t     out_addr_x;
    word_t     out_addr_y;
    logic      out_x_sel;
    logic      out_y_sel;
    issue_op_t out_op;
    logic      out_we;
    word_t     out_addr_z;

    // program rom, address 0 is never fetched
    inst_t rom [256];
    string test_name [256];
    int    prog_end;
    pc_t   rom_pc = '0;

    logic [15:0] lfsr_state;

    // expected streams in program order
    pc_t        exp_pc_q [$];
    issue_op_t  exp_op_q [$];
    string      exp_op_name_q [$];
    word_t      exp_x_q [$];
    word_t      exp_y_q [$];
    logic [1:0] exp_sel_q [$];
    word_t      exp_z_q [$];
    string      exp_z_name_q [$];

    // address pairs seen over the last issue depth cycles
    word_t      hist_x [`MLACC_ISSUE_DEPTH+1];
    word_t      hist_y [`MLACC_ISSUE_DEPTH+1];
    // x and y selects seen with the address pairs
    logic [1:0] hist_sel [`MLACC_ISSUE_DEPTH+1];
    pc_t        last_pc;
    logic       pc_seen = 1'b0;

    int total_steps = 0;
    int timeout_limit = 0;
    int cycle_count = 0;
    int pc_errors = 0;
    int op_errors = 0;
    int word_errors = 0;
    int sel_errors = 0;
    int other_errors = 0;

    mlacc_ctrl dut (
        .in_clk     (in_clk),
        .in_reset   (in_reset),
        .in_inst    (in_inst),
        .out_pc     (out_pc),
        .out_addr_x (out_addr_x),
        .out_addr_y (out_addr_y),
        .out_x_sel  (out_x_sel),
        .out_y_sel  (out_y_sel),
        .out_op     (out_op),
        .out_we     (out_we),
        .out_addr_z (out_addr_z)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[`MLACC_WORD_W-2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic is_vector(input funct_e f);
        return !(f inside {funct_nop, funct_raddi, funct_loop});
    endfunction

    function automatic inst_t vec_word(input funct_e f, input int n, input logic xf,
                                       input logic yf, input logic zf, input word_t xb,
                                       input word_t yb, input word_t zb);
        inst_t w;
        w = '0;
        w[funct_hi:funct_lo] = f;
        w[len_hi:len_lo] = len_t'(n - 1);
        w[x_flag_bit] = xf;
        w[y_flag_bit] = yf;
        w[z_flag_bit] = zf;
        w[x_base_lo +: `MLACC_ENC_ADDR_W] = xb[`MLACC_ENC_ADDR_W-1:0];
        w[y_base_lo +: `MLACC_ENC_ADDR_W] = yb[`MLACC_ENC_ADDR_W-1:0];
        w[z_base_lo +: `MLACC_ENC_ADDR_W] = zb[`MLACC_ENC_ADDR_W-1:0];
        return w;
    endfunction

    function automatic inst_t raddi_word(input reg_idx_e r, input word_t imm);
        inst_t w;
        w = '0;
        w[funct_hi:funct_lo] = funct_raddi;
        w[imm_lo +: `MLACC_WORD_W] = imm;
        w[reg_idx_lo +: 5] = r;
        return w;
    endfunction

    function automatic inst_t loop_word(input pc_t end_pc, input word_t count);
        inst_t w;
        w = '0;
        w[funct_hi:funct_lo] = funct_loop;
        w[loop_end_lo +: `MLACC_PC_W] = end_pc;
        w[loop_count_lo +: `MLACC_WORD_W] = count;
        return w;
    endfunction

    task automatic add_word(input string name, input inst_t w);
        rom[prog_end] = w;
        test_name[prog_end] = name;
        prog_end++;
    endtask

    task automatic add_nops(input int count);
        for (int i = 0; i < count; i++) begin
            add_word("nop", '0);
        end
    endtask

    task automatic add_vector(input string name, input funct_e f, input int len_bits,
                              input logic xf, input logic yf, input logic zf);
        word_t n;
        word_t xb;
        word_t yb;
        word_t zb;
        take_bits(len_bits, n);
        take_bits(`MLACC_ENC_ADDR_W, xb);
        take_bits(`MLACC_ENC_ADDR_W, yb);
        take_bits(`MLACC_ENC_ADDR_W, zb);
        add_word(name, vec_word(f, int'(n) + 1, xf, yf, zf, xb, yb, zb));
    endtask

    task automatic build_program();
        word_t imm;
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
            test_name[i] = "nop";
        end
        prog_end = 1;
        add_vector("vadd_basic", funct_vadd, 6, 1'b0, 1'b0, 1'b0);
        add_vector("vsslt_scalar", funct_vsslt, 6, 1'b0, 1'b0, 1'b0);
        add_vector("vsub_short", funct_vsub, 2, 1'b0, 1'b0, 1'b0);
        take_bits(`MLACC_WORD_W, imm);
        add_word("raddi_x", raddi_word(reg_x_load, imm));
        add_nops(4);
        take_bits(`MLACC_WORD_W, imm);
        add_word("raddi_z", raddi_word(reg_z_store, imm));
        add_nops(4);
        add_vector("offset_vmul", funct_vmul, 5, 1'b1, 1'b0, 1'b1);
        add_vector("plain_vadd", funct_vadd, 4, 1'b0, 1'b0, 1'b0);
        // three-word block run three times in all
        add_word("loop_word", loop_word(pc_t'(prog_end + 3), word_t'(2)));
        add_vector("loop_vact0", funct_vact0, 4, 1'b0, 1'b0, 1'b0);
        add_vector("loop_vslt", funct_vslt, 3, 1'b1, 1'b0, 1'b1);
        add_vector("loop_vact2", funct_vact2, 4, 1'b0, 1'b0, 1'b0);
        add_vector("after_vact1", funct_vact1, 3, 1'b0, 1'b0, 1'b0);
        take_bits(`MLACC_WORD_W, imm);
        add_word("raddi_y", raddi_word(reg_y_load, imm));
        add_nops(4);
        add_vector("offset_vsslt", funct_vsslt, 4, 1'b1, 1'b1, 1'b1);
    endtask

    // walk the program in fetch order and expand every word into its steps
    function automatic void build_expected();
        int         pc;
        int         lbegin;
        int         lend;
        int         lrem;
        int         n;
        int         nsteps;
        word_t      off_x;
        word_t      off_y;
        word_t      off_z;
        word_t      bx;
        word_t      by;
        word_t      bz;
        word_t      step_off;
        inst_t      w;
        funct_e     f;
        lane_mask_t lane;
        pc = 1;
        lbegin = 0;
        lend = 0;
        lrem = 0;
        off_x = '0;
        off_y = '0;
        off_z = '0;
        while (pc < prog_end) begin
            w = rom[pc];
            f = funct_e'(w[funct_hi:funct_lo]);
            exp_pc_q.push_back(pc_t'(pc));
            if (f == funct_nop) begin
                total_steps++;
            end else if (!is_vector(f)) begin
                total_steps++;
                exp_op_q.push_back('{funct: f, lane_mask: 2'd0});
                exp_op_name_q.push_back(test_name[pc]);
                if (f == funct_loop) begin
                    lbegin = pc + 1;
                    lend = int'(w[loop_end_lo +: `MLACC_PC_W]);
                    lrem = int'(w[loop_count_lo +: `MLACC_WORD_W]);
                end else begin
                    case (reg_idx_e'(w[reg_idx_lo +: 5]))
                        reg_x_load:  off_x = off_x + w[imm_lo +: `MLACC_WORD_W];
                        reg_y_load:  off_y = off_y + w[imm_lo +: `MLACC_WORD_W];
                        reg_z_store: off_z = off_z + w[imm_lo +: `MLACC_WORD_W];
                        default: ;
                    endcase
                end
            end else begin
                n = int'(w[len_hi:len_lo]) + 1;
                nsteps = (n + 3) / 4;
                bx = {w[x_base_lo +: `MLACC_ENC_ADDR_W], 1'b0} + (w[x_flag_bit] ? off_x : '0);
                by = {w[y_base_lo +: `MLACC_ENC_ADDR_W], 1'b0} + (w[y_flag_bit] ? off_y : '0);
                bz = {w[z_base_lo +: `MLACC_ENC_ADDR_W], 1'b0} + (w[z_flag_bit] ? off_z : '0);
                for (int i = 0; i < nsteps; i++) begin
                    lane = (i == nsteps - 1) ? lane_mask_t'((n - 1) % 4) : 2'd3;
                    step_off = word_t'(`MLACC_STEP_BYTES * i);
                    exp_op_q.push_back('{funct: f, lane_mask: lane});
                    exp_op_name_q.push_back($sformatf("%s step %0d", test_name[pc], i));
                    exp_x_q.push_back(bx + step_off);
                    exp_y_q.push_back(f == funct_vsslt ? by : by + step_off);
                    exp_sel_q.push_back({w[x_base_lo + `MLACC_ENC_ADDR_W - 1],
                                         w[y_base_lo + `MLACC_ENC_ADDR_W - 1]});
                    exp_z_q.push_back(bz + step_off);
                    exp_z_name_q.push_back($sformatf("%s write %0d", test_name[pc], i));
                end
                total_steps += nsteps;
            end
            if (lrem != 0 && pc == lend) begin
                pc = lbegin;
                lrem--;
            end else begin
                pc++;
            end
        end
    endfunction

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            word_errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_sel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            sel_errors++;
            $display("error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic compare_op(input string name, input issue_op_t expected,
                              input issue_op_t actual);
        if (actual !== expected) begin
            op_errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            pc_errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("mismatch counts: pc %0d, op %0d, address %0d, select %0d, other %0d",
                 pc_errors, op_errors, word_errors, sel_errors, other_errors);
    endtask

    initial begin
        in_clk = 1'b0;
        forever #4 in_clk = ~in_clk;
    end

    // rom answers with the word at the pc of the cycle before
    always @(negedge in_clk) begin
        rom_pc = out_pc;
    end

    initial begin
        in_inst = '0;
        forever begin
            @(posedge in_clk);
            #1;
            in_inst = rom[rom_pc];
        end
    end

    always @(negedge in_clk) begin : check_streams
        string      name;
        issue_op_t  exp_op;
        logic [1:0] exp_sel;
        for (int i = `MLACC_ISSUE_DEPTH; i > 0; i--) begin
            hist_x[i] = hist_x[i-1];
            hist_y[i] = hist_y[i-1];
            hist_sel[i] = hist_sel[i-1];
        end
        hist_x[0] = out_addr_x;
        hist_y[0] = out_addr_y;
        hist_sel[0] = {out_x_sel, out_y_sel};
        if (!in_reset) begin
            if (!pc_seen || out_pc !== last_pc) begin
                if (exp_pc_q.size() > 0) begin
                    compare_pc("pc stream", exp_pc_q.pop_front(), out_pc);
                end
                pc_seen = 1'b1;
                last_pc = out_pc;
            end
            if (out_op.funct === funct_nop) begin
                compare_op("idle op", idle_op, out_op);
            end else if (exp_op_q.size() == 0) begin
                other_errors++;
                $display("operation %h issued after the last expected step", out_op);
            end else begin
                name = exp_op_name_q.pop_front();
                exp_op = exp_op_q.pop_front();
                compare_op(name, exp_op, out_op);
                // operands left the address stage three cycles ago
                if (is_vector(exp_op.funct)) begin
                    compare_word({name, " x"}, exp_x_q.pop_front(), hist_x[`MLACC_ISSUE_DEPTH]);
                    compare_word({name, " y"}, exp_y_q.pop_front(), hist_y[`MLACC_ISSUE_DEPTH]);
                    exp_sel = exp_sel_q.pop_front();
                    compare_sel({name, " x sel"}, exp_sel[1], hist_sel[`MLACC_ISSUE_DEPTH][1]);
                    compare_sel({name, " y sel"}, exp_sel[0], hist_sel[`MLACC_ISSUE_DEPTH][0]);
                end
            end
            if (out_we === 1'b1) begin
                if (exp_z_q.size() == 0) begin
                    other_errors++;
                    $display("write to %h when no write was expected", out_addr_z);
                end else begin
                    compare_word(exp_z_name_q.pop_front(), exp_z_q.pop_front(), out_addr_z);
                end
            end else if (out_we !== 1'b0) begin
                other_errors++;
                $display("write enable is unknown");
            end
        end
    end

    always @(posedge in_clk) begin
        if (!in_reset) begin
            cycle_count++;
            if (cycle_count > timeout_limit) begin
                $display("timeout after %0d cycles with results still outstanding", cycle_count);
                print_counts();
                $display("Finished with errors");
                $finish;
            end
        end
    end

    initial begin
        in_reset = 1'b1;
        lfsr_state = 16'd53;
        build_program();
        build_expected();
        timeout_limit = total_steps + 50;
        repeat (4) @(posedge in_clk);
        #1;
        in_reset = 1'b0;
        while (exp_pc_q.size() + exp_op_q.size() + exp_z_q.size() != 0) begin
            @(posedge in_clk);
        end
        // a few idle cycles to catch stray writes
        repeat (8) @(posedge in_clk);
        print_counts();
        if (pc_errors + op_errors + word_errors + sel_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/mlacc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlacc_ctrl (
    input  logic                      in_clk,
    input  logic                      in_reset,
    input  mlacc_isa_pkg::inst_t      in_inst,
    output mlacc_isa_pkg::pc_t        out_pc,
    output mlacc_isa_pkg::word_t      out_addr_x,
    output mlacc_isa_pkg::word_t      out_addr_y,
    output logic                      out_x_sel,
    output logic                      out_y_sel,
    output mlacc_ctrl_pkg::issue_op_t out_op,
    output logic                      out_we,
    output mlacc_isa_pkg::word_t      out_addr_z
);
    import mlacc_isa_pkg::*;
    import mlacc_ctrl_pkg::*;

    logic     inst_done;
    logic     fetch_advance;
    pc_t      word_pc;
    offsets_t offsets;
    step_t    step;
    step_t    step_exec;
    logic     step_valid;

    // pc of the word now on in_inst
    always_ff @(posedge in_clk) begin
        if (in_reset) begin
            word_pc <= '0;
        end else begin
            word_pc <= out_pc;
        end
    end

    inst_fetch u_inst_fetch (
        .in_clk        (in_clk),
        .in_reset      (in_reset),
        .inst          (in_inst),
        .inst_done     (inst_done),
        .fetch_advance (fetch_advance),
        .word_pc       (word_pc),
        .pc            (out_pc)
    );

    vector_sequencer u_vector_sequencer (
        .in_clk        (in_clk),
        .in_reset      (in_reset),
        .inst          (in_inst),
        .offsets       (offsets),
        .inst_done     (inst_done),
        .fetch_advance (fetch_advance),
        .addr_x        (out_addr_x),
        .addr_y        (out_addr_y),
        .x_sel         (out_x_sel),
        .y_sel         (out_y_sel),
        .step          (step),
        .step_valid    (step_valid)
    );

    offset_regfile u_offset_regfile (
        .in_clk     (in_clk),
        .in_reset   (in_reset),
        .step_in    (step),
        .step_valid (step_valid),
        .offsets    (offsets),
        .op         (out_op),
        .step_exec  (step_exec)
    );

    writeback_pipe u_writeback_pipe (
        .in_clk    (in_clk),
        .in_reset  (in_reset),
        .step_exec (step_exec),
        .offsets   (offsets),
        .we        (out_we),
        .addr_z    (out_addr_z)
    );

endmodule

`default_nettype wire

// ==== source/writeback_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mlacc_cfg.svh"

module writeback_pipe (
    input  logic                     in_clk,
    input  logic                     in_reset,
    input  mlacc_ctrl_pkg::step_t    step_exec,
    input  mlacc_ctrl_pkg::offsets_t offsets,
    output logic                     we,
    output mlacc_isa_pkg::word_t     addr_z
);
    import mlacc_isa_pkg::*;
    import mlacc_ctrl_pkg::*;

    logic  we_q [`MLACC_RESULT_DEPTH];
    word_t addr_q [`MLACC_RESULT_DEPTH];
    logic  z_flag_q;
    word_t addr_store;

    // store offset as it stands after any raddi at execute
    assign addr_store = z_flag_q ? addr_q[0] + offsets.z_store : addr_q[0];

    always_ff @(posedge in_clk) begin
        if (in_reset) begin
            for (int i = 0; i < `MLACC_RESULT_DEPTH; i++) begin
                we_q[i] <= 1'b0;
            end
        end else begin
            we_q[0] <= step_exec.we;
            for (int i = 1; i < `MLACC_RESULT_DEPTH; i++) begin
                we_q[i] <= we_q[i-1];
            end
        end
    end

    always_ff @(posedge in_clk) begin
        addr_q[0] <= step_exec.addr_z;
        z_flag_q <= step_exec.z_flag;
        addr_q[1] <= addr_store;
        for (int i = 2; i < `MLACC_RESULT_DEPTH; i++) begin
            addr_q[i] <= addr_q[i-1];
        end
    end

    assign we = we_q[`MLACC_RESULT_DEPTH-1];
    assign addr_z = addr_q[`MLACC_RESULT_DEPTH-1];

endmodule

`default_nettype wire

// ==== source/offset_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mlacc_cfg.svh"

module offset_regfile (
    input  logic                      in_clk,
    input  logic                      in_reset,
    input  mlacc_ctrl_pkg::step_t     step_in,
    input  logic                      step_valid,
    output mlacc_ctrl_pkg::offsets_t  offsets,
    output mlacc_ctrl_pkg::issue_op_t op,
    output mlacc_ctrl_pkg::step_t     step_exec
);
    import mlacc_isa_pkg::*;
    import mlacc_ctrl_pkg::*;

    // step records from the address stage to execute
    step_t delay_q [`MLACC_ISSUE_DEPTH];
    logic  is_raddi;

    always_ff @(posedge in_clk) begin
        if (in_reset) begin
            for (int i = 0; i < `MLACC_ISSUE_DEPTH; i++) begin
                delay_q[i] <= step_t'('0);
            end
        end else begin
            // startup steps enter as nops
            delay_q[0] <= step_valid ? step_in : step_t'('0);
            for (int i = 1; i < `MLACC_ISSUE_DEPTH; i++) begin
                delay_q[i] <= delay_q[i-1];
            end
        end
    end

    assign step_exec = delay_q[`MLACC_ISSUE_DEPTH-1];

    assign op.funct = step_exec.funct;
    assign op.lane_mask = step_exec.lane_mask;

    assign is_raddi = (step_exec.funct == funct_raddi);

    // new value is seen by addresses from the next cycle on
    always_ff @(posedge in_clk) begin
        if (in_reset) begin
            offsets <= offsets_t'('0);
        end else if (is_raddi) begin
            case (step_exec.reg_idx)
                reg_x_load:  offsets.x_load <= offsets.x_load + step_exec.imm;
                reg_y_load:  offsets.y_load <= offsets.y_load + step_exec.imm;
                reg_z_store: offsets.z_store <= offsets.z_store + step_exec.imm;
                default: ;
            endcase
        end
    end

    // index decoded at fetch must name a real offset register
    assert property (@(posedge in_clk) disable iff (in_reset)
        is_raddi |-> (step_exec.reg_idx inside {reg_x_load, reg_y_load, reg_z_store}));

endmodule

`default_nettype wire

// ==== source/vector_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mlacc_cfg.svh"

module vector_sequencer (
    input  logic                     in_clk,
    input  logic                     in_reset,
    input  mlacc_isa_pkg::inst_t     inst,
    input  mlacc_ctrl_pkg::offsets_t offsets,
    output logic                     inst_done,
    output logic                     fetch_advance,
    output mlacc_isa_pkg::word_t     addr_x,
    output mlacc_isa_pkg::word_t     addr_y,
    output logic                     x_sel,
    output logic                     y_sel,
    output mlacc_ctrl_pkg::step_t    step,
    output logic                     step_valid
);
    import mlacc_isa_pkg::*;
    import mlacc_ctrl_pkg::*;

    // instruction being stepped
    funct_e   funct;
    len_t     len;
    word_t    cur_x;
    word_t    cur_y;
    word_t    cur_z;
    logic     x_flag;
    logic     y_flag;
    logic     z_flag;
    word_t    imm;
    reg_idx_e reg_idx;
    logic     cur_valid;

    // word on the instruction bus
    funct_e   in_funct;
    len_t     in_len;
    logic     in_short;
    logic     last_step;
    logic     next_last;

    assign in_funct = funct_e'(inst[funct_hi:funct_lo]);
    assign in_len = inst[len_hi:len_lo];

    // words that finish in a single step
    assign in_short = (in_funct inside {funct_raddi, funct_loop})
        || (in_len[`MLACC_LEN_W-1:2] == '0);

    assign last_step = (len[`MLACC_LEN_W-1:2] == '0);
    assign next_last = (len[`MLACC_LEN_W-1:2] == 'd1);

    assign inst_done = last_step;
    // fetch one cycle ahead so the next word is waiting at the last step
    assign fetch_advance = (inst_done && in_short) || next_last;

    assign addr_x = cur_x + (x_flag ? offsets.x_load : '0);
    assign addr_y = cur_y + (y_flag ? offsets.y_load : '0);

    assign step_valid = cur_valid;

    always_comb begin
        step.funct = funct;
        step.we = !(funct inside {funct_nop, funct_raddi, funct_loop});
        step.lane_mask = last_step ? len[1:0] : 2'd3;
        step.addr_z = cur_z;
        step.z_flag = z_flag;
        step.reg_idx = reg_idx;
        step.imm = imm;
    end

    always_ff @(posedge in_clk) begin
        if (in_reset) begin
            // wait out the first fetch as if a nop were running
            funct <= funct_nop;
            len <= len_t'(`MLACC_START_LATENCY);
            cur_x <= '0;
            cur_y <= '0;
            cur_z <= '0;
            x_sel <= 1'b0;
            y_sel <= 1'b0;
            x_flag <= 1'b0;
            y_flag <= 1'b0;
            z_flag <= 1'b0;
            cur_valid <= 1'b0;
        end else if (inst_done) begin
            funct <= in_funct;
            len <= in_len;
            cur_x <= base_addr(inst[x_base_lo +: `MLACC_ENC_ADDR_W]);
            cur_y <= base_addr(inst[y_base_lo +: `MLACC_ENC_ADDR_W]);
            cur_z <= base_addr(inst[z_base_lo +: `MLACC_ENC_ADDR_W]);
            // memory select is the top bit of the base field
            x_sel <= inst[x_base_lo + `MLACC_ENC_ADDR_W - 1];
            y_sel <= inst[y_base_lo + `MLACC_ENC_ADDR_W - 1];
            x_flag <= inst[x_flag_bit];
            y_flag <= inst[y_flag_bit];
            z_flag <= inst[z_flag_bit];
            cur_valid <= 1'b1;
        end else begin
            len <= len - len_t'(4);
            cur_x <= cur_x + `MLACC_STEP_BYTES;
            // scalar operand of vsslt stays put
            if (funct != funct_vsslt) begin
                cur_y <= cur_y + `MLACC_STEP_BYTES;
            end
            cur_z <= cur_z + `MLACC_STEP_BYTES;
        end
    end

    // raddi operands, only meaningful once a word is latched
    always_ff @(posedge in_clk) begin
        if (inst_done) begin
            imm <= inst[imm_lo +: `MLACC_WORD_W];
            reg_idx <= reg_idx_e'(inst[reg_idx_lo +: 5]);
        end
    end

    // an early fetch always lands one cycle before the last step
    assert property (@(posedge in_clk) disable iff (in_reset)
        (fetch_advance && !inst_done) |=> inst_done);

endmodule

`default_nettype wire

// ==== source/inst_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mlacc_cfg.svh"

module inst_fetch (
    input  logic                 in_clk,
    input  logic                 in_reset,
    input  mlacc_isa_pkg::inst_t inst,
    input  logic                 inst_done,
    input  logic                 fetch_advance,
    input  mlacc_isa_pkg::pc_t   word_pc,
    output mlacc_isa_pkg::pc_t   pc
);
    import mlacc_isa_pkg::*;

    pc_t   fetch_pc;
    pc_t   loop_begin;
    pc_t   loop_end;
    // iterations still to run
    word_t loop_n;
    logic  loop_load;
    logic  should_jump;

    assign loop_load = inst_done && (funct_e'(inst[funct_hi:funct_lo]) == funct_loop);

    // back to the loop start when the end of the block is fetched
    assign should_jump = (loop_n != '0) && (fetch_pc == loop_end);
    assign pc = should_jump ? loop_begin : fetch_pc + 1'b1;

    always_ff @(posedge in_clk) begin
        if (in_reset) begin
            fetch_pc <= '0;
        end else if (fetch_advance) begin
            fetch_pc <= pc;
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_reset) begin
            loop_begin <= '0;
            loop_end <= '0;
            loop_n <= '0;
        end else if (loop_load) begin
            // block starts right after the loop word
            loop_begin <= word_pc + 1'b1;
            loop_end <= inst[loop_end_lo +: `MLACC_PC_W];
            loop_n <= inst[loop_count_lo +: `MLACC_WORD_W];
        end else if (fetch_advance && should_jump) begin
            loop_n <= loop_n - 1'b1;
        end
    end

    // an exhausted count stays at zero until a new loop word arrives
    assert property (@(posedge in_clk) disable iff (in_reset)
        (loop_n == '0 && !loop_load) |=> loop_n == '0);

endmodule

`default_nettype wire

// ==== source/mlacc_ctrl_pkg.sv ====
`default_nettype none

package mlacc_ctrl_pkg;

    // index of the last active lane, 0 to 3
    typedef logic [1:0] lane_mask_t;

    // one step of a vector instruction as it travels down the pipeline
    typedef struct packed {
        mlacc_isa_pkg::funct_e   funct;
        logic                    we;
        lane_mask_t              lane_mask;
        // z address before the store offset
        mlacc_isa_pkg::word_t    addr_z;
        logic                    z_flag;
        mlacc_isa_pkg::reg_idx_e reg_idx;
        mlacc_isa_pkg::word_t    imm;
    } step_t;

    // operation seen by the datapath at execute
    typedef struct packed {
        mlacc_isa_pkg::funct_e funct;
        lane_mask_t            lane_mask;
    } issue_op_t;

    typedef struct packed {
        mlacc_isa_pkg::word_t x_load;
        mlacc_isa_pkg::word_t y_load;
        mlacc_isa_pkg::word_t z_store;
    } offsets_t;

endpackage

`default_nettype wire

// ==== source/mlacc_isa_pkg.sv ====
`default_nettype none

`include "mlacc_cfg.svh"

package mlacc_isa_pkg;

    typedef logic [127:0] inst_t;
    typedef logic [`MLACC_LEN_W-1:0] len_t;
    typedef logic [`MLACC_WORD_W-1:0] word_t;
    typedef logic [`MLACC_PC_W-1:0] pc_t;
    typedef logic [`MLACC_ENC_ADDR_W-1:0] enc_addr_t;

    // function codes, gaps are unused encodings
    typedef enum logic [3:0] {
        funct_nop   = 4'd0,
        funct_raddi = 4'd1,
        funct_vslt  = 4'd2,
        funct_vsub  = 4'd3,
        funct_vadd  = 4'd4,
        funct_vmul  = 4'd5,
        funct_vact0 = 4'd6,
        funct_vact1 = 4'd7,
        funct_vact2 = 4'd8,
        funct_vsslt = 4'd10,
        funct_loop  = 4'd13
    } funct_e;

    // offset registers reachable by raddi
    typedef enum logic [4:0] {
        reg_x_load  = 5'd2,
        reg_y_load  = 5'd3,
        reg_z_store = 5'd4
    } reg_idx_e;

    // field positions in the instruction word
    localparam int funct_hi = 127;
    localparam int funct_lo = 124;
    localparam int len_hi = 123;
    localparam int len_lo = 110;
    localparam int x_flag_bit = 95;
    localparam int y_flag_bit = 63;
    localparam int z_flag_bit = 31;
    localparam int x_base_lo = 64;
    localparam int y_base_lo = 32;
    localparam int z_base_lo = 0;
    localparam int imm_lo = 64;
    localparam int reg_idx_lo = 32;
    localparam int loop_end_lo = 64;
    localparam int loop_count_lo = 32;

    // encoded base field to byte address
    function automatic word_t base_addr(enc_addr_t field);
        return {field, 1'b0};
    endfunction

endpackage

`default_nettype wire

// ==== include/mlacc_cfg.svh ====
`ifndef MLACC_CFG_SVH
`define MLACC_CFG_SVH

// address and offset word
`define MLACC_WORD_W 32
`define MLACC_PC_W 8
// element count field holds count minus one
`define MLACC_LEN_W 14
// base fields are stored as half addresses
`define MLACC_ENC_ADDR_W 31

// address stage to execute
`define MLACC_ISSUE_DEPTH 3
// execute to the write outputs
`define MLACC_RESULT_DEPTH 4

// one instruction latency of waiting after reset
`define MLACC_START_LATENCY 4
// four 32-bit lanes per step
`define MLACC_STEP_BYTES 16

`endif
